/* alu.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module alu (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  instrPkg::dpOpT     op,
  input  logic               memAccess,
  input  logic               addOffset,
  output logic [`DATA_W-1:0] y
);

  logic [`DATA_W-1:0] dpResult;
  logic [`DATA_W-1:0] addrResult;

  // ====================
  // Data processing
  // ====================
  always_comb begin
    case (op)
      instrPkg::OP_AND: dpResult = a & b;
      instrPkg::OP_EOR: dpResult = a ^ b;
      instrPkg::OP_SUB: dpResult = a - b;
      // Reverse subtract
      instrPkg::OP_RSB: dpResult = b - a;
      instrPkg::OP_ADD: dpResult = a + b;
      instrPkg::OP_ORR: dpResult = a | b;
      // Moves ignore the first operand
      instrPkg::OP_MOV: dpResult = b;
      instrPkg::OP_MVN: dpResult = ~b;
      default:          dpResult = '0;
    endcase
  end

  // ====================
  // Load/store address
  // ====================

  // U bit picks base plus or minus offset
  assign addrResult = addOffset ? (a + b) : (a - b);

  // Memory accesses override the opcode
  assign y = memAccess ? addrResult : dpResult;

endmodule

/* armCore.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module armCore (
  input  logic               clk,
  input  logic               arstN,
  input  logic [`DATA_W-1:0] instrF,
  input  logic [`DATA_W-1:0] readDataM,
  output logic [`DATA_W-1:0] pcF,
  output logic [`DATA_W-1:0] aluOutM,
  output logic [`DATA_W-1:0] writeDataM,
  output logic               dataWe
);

  // Decode stage
  logic [31:0]        instrD;
  instrPkg::dpOpT     aluOpD;
  instrPkg::shiftT    shiftTypeD;
  instrPkg::srcBT     srcBD;
  logic               regWriteD, memWriteD, memAccessD, addOffsetD;
  pipePkg::resSelT    resultSelD;
  logic [`REG_AW-1:0] ra1D, ra2D, waD;

  // Hazard handshake
  logic [`REG_AW-1:0] ra1E, ra2E, waE, waM, waW;
  logic               loadE, regWriteM, regWriteW;
  pipePkg::fwdT       forwardAE, forwardBE;
  logic               stallF, stallD, flushE;

  decoder dec (.instrD(instrD), .aluOpD(aluOpD), .shiftTypeD(shiftTypeD), .srcBD(srcBD),
               .regWriteD(regWriteD), .memWriteD(memWriteD), .memAccessD(memAccessD),
               .addOffsetD(addOffsetD), .resultSelD(resultSelD),
               .ra1D(ra1D), .ra2D(ra2D), .waD(waD));

  hazardUnit hzd (.ra1E(ra1E), .ra2E(ra2E), .waM(waM), .waW(waW), .ra1D(ra1D),
                  .ra2D(ra2D), .waE(waE), .regWriteM(regWriteM), .regWriteW(regWriteW),
                  .loadE(loadE), .forwardAE(forwardAE), .forwardBE(forwardBE),
                  .stallF(stallF), .stallD(stallD), .flushE(flushE));

  datapath dp (.clk(clk), .arstN(arstN), .instrF(instrF), .readDataM(readDataM),
               .pcF(pcF), .aluOutM(aluOutM), .writeDataM(writeDataM), .dataWe(dataWe),
               .instrD(instrD), .aluOpD(aluOpD), .shiftTypeD(shiftTypeD), .srcBD(srcBD),
               .regWriteD(regWriteD), .memWriteD(memWriteD), .memAccessD(memAccessD),
               .addOffsetD(addOffsetD), .resultSelD(resultSelD),
               .ra1D(ra1D), .ra2D(ra2D), .waD(waD),
               .forwardAE(forwardAE), .forwardBE(forwardBE),
               .stallF(stallF), .stallD(stallD), .flushE(flushE),
               .ra1E(ra1E), .ra2E(ra2E), .waE(waE), .waM(waM), .waW(waW),
               .loadE(loadE), .regWriteM(regWriteM), .regWriteW(regWriteW));

endmodule

/* armCore_asserts.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module armCore_asserts (
  input logic               clk,
  input logic               arstN,
  input logic               dataWe,
  input logic [`DATA_W-1:0] pcF,
  input logic               stallF,
  input logic               stallD
);

  // Number of failed checks
  int failCount = 0;

  // ====================
  // Pipeline control
  // ====================

  // Store strobe stays low while in reset
  noStoreInReset: assert property (@(posedge clk) !arstN |-> !dataWe)
    else begin
      failCount++;
      $error("dataWe high while arstN low");
    end

  // A fetch stall holds the PC for the next edge
  pcHeldOnStall: assert property (@(posedge clk) disable iff (!arstN)
                                  stallF |=> $stable(pcF))
    else begin
      failCount++;
      $error("pcF moved during a fetch stall");
    end

  // Fetch and decode stall together
  stallsMatch: assert property (@(posedge clk) disable iff (!arstN)
                                stallF == stallD)
    else begin
      failCount++;
      $error("stallF and stallD differ");
    end

endmodule

/* core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ====================
// Core sizing
// ====================

// Data and address width
`define DATA_W 32

// Register file size and address width
`define NUM_REGS 16
`define REG_AW 4

// ====================
// Reset state
// ====================

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* datapath.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module datapath (
  input  logic               clk,
  input  logic               arstN,
  input  logic [`DATA_W-1:0] instrF,
  input  logic [`DATA_W-1:0] readDataM,
  output logic [`DATA_W-1:0] pcF,
  output logic [`DATA_W-1:0] aluOutM,
  output logic [`DATA_W-1:0] writeDataM,
  output logic               dataWe,
  output logic [31:0]        instrD,
  // Decode-stage controls
  input  instrPkg::dpOpT     aluOpD,
  input  instrPkg::shiftT    shiftTypeD,
  input  instrPkg::srcBT     srcBD,
  input  logic               regWriteD,
  input  logic               memWriteD,
  input  logic               memAccessD,
  input  logic               addOffsetD,
  input  pipePkg::resSelT    resultSelD,
  input  logic [`REG_AW-1:0] ra1D,
  input  logic [`REG_AW-1:0] ra2D,
  input  logic [`REG_AW-1:0] waD,
  // Hazard controls
  input  pipePkg::fwdT       forwardAE,
  input  pipePkg::fwdT       forwardBE,
  input  logic               stallF,
  input  logic               stallD,
  input  logic               flushE,
  // To the hazard unit
  output logic [`REG_AW-1:0] ra1E,
  output logic [`REG_AW-1:0] ra2E,
  output logic [`REG_AW-1:0] waE,
  output logic [`REG_AW-1:0] waM,
  output logic [`REG_AW-1:0] waW,
  output logic               loadE,
  output logic               regWriteM,
  output logic               regWriteW
);

  logic                 validD;
  logic [`DATA_W-1:0]   rd1D, rd2D, rd1E, rd2E;
  logic [31:0]          instrE;
  logic                 regWriteE, memWriteE, memAccessE, addOffsetE;
  instrPkg::dpOpT       aluOpE;
  instrPkg::shiftT      shiftTypeE;
  instrPkg::srcBT       srcBE;
  pipePkg::resSelT      resultSelE, resultSelM, resultSelW;
  logic [`DATA_W-1:0]   srcAE, writeDataE, operandE, aluResultE;
  logic                 memWriteM;
  logic [`DATA_W-1:0]   aluOutW, readDataW, resultW;

  // ====================
  // Fetch
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= `RESET_PC;
    end else if (!stallF) begin
      pcF <= pcF + `DATA_W'd4;
    end
  end

  // ====================
  // Decode
  // ====================

  // Valid bit keeps the empty decode slot after reset from writing
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validD <= 1'b0;
    end else if (!stallD) begin
      validD <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      instrD <= instrF;
    end
  end

  regFile rf (.clk(clk), .arstN(arstN), .we(regWriteW), .ra1(ra1D), .ra2(ra2D),
              .wa(waW), .wd(resultW), .rd1(rd1D), .rd2(rd2D));

  // ====================
  // Execute
  // ====================

  // A flush leaves the write enables clear, giving a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memAccessE <= 1'b0;
      addOffsetE <= 1'b0;
      aluOpE     <= instrPkg::OP_AND;
      shiftTypeE <= instrPkg::SH_LSL;
      srcBE      <= instrPkg::SRC_SHREG;
      resultSelE <= pipePkg::RES_ALU;
      ra1E       <= '0;
      ra2E       <= '0;
      waE        <= '0;
    end else begin
      regWriteE  <= regWriteD & validD & ~flushE;
      memWriteE  <= memWriteD & validD & ~flushE;
      memAccessE <= memAccessD;
      addOffsetE <= addOffsetD;
      aluOpE     <= aluOpD;
      shiftTypeE <= shiftTypeD;
      srcBE      <= srcBD;
      resultSelE <= resultSelD;
      ra1E       <= ra1D;
      ra2E       <= ra2D;
      waE        <= waD;
    end
  end

  always_ff @(posedge clk) begin
    rd1E   <= rd1D;
    rd2E   <= rd2D;
    instrE <= instrD;
  end

  // Only a load that really writes counts for load-use
  assign loadE = regWriteE && (resultSelE == pipePkg::RES_MEM);

  // Operand forwarding ahead of the shifter
  always_comb begin
    case (forwardAE)
      pipePkg::FWD_MEM: srcAE = aluOutM;
      pipePkg::FWD_WB:  srcAE = resultW;
      default:          srcAE = rd1E;
    endcase
    case (forwardBE)
      pipePkg::FWD_MEM: writeDataE = aluOutM;
      pipePkg::FWD_WB:  writeDataE = resultW;
      default:          writeDataE = rd2E;
    endcase
  end

  shifter sh (.srcB(srcBE), .instr(instrE), .rm(writeDataE), .shiftType(shiftTypeE),
              .operand(operandE));

  alu alu0 (.a(srcAE), .b(operandE), .op(aluOpE), .memAccess(memAccessE),
            .addOffset(addOffsetE), .y(aluResultE));

  // ====================
  // Memory
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSelM <= pipePkg::RES_ALU;
      waM        <= '0;
    end else begin
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      resultSelM <= resultSelE;
      waM        <= waE;
    end
  end

  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
  end

  // Store strobe for exactly the memory cycle
  assign dataWe = memWriteM;

  // ====================
  // Writeback
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteW  <= 1'b0;
      resultSelW <= pipePkg::RES_ALU;
      waW        <= '0;
    end else begin
      regWriteW  <= regWriteM;
      resultSelW <= resultSelM;
      waW        <= waM;
    end
  end

  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
  end

  assign resultW = (resultSelW == pipePkg::RES_MEM) ? readDataW : aluOutW;

endmodule

/* decoder.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module decoder (
  input  logic [31:0]        instrD,
  output instrPkg::dpOpT     aluOpD,
  output instrPkg::shiftT    shiftTypeD,
  output instrPkg::srcBT     srcBD,
  output logic               regWriteD,
  output logic               memWriteD,
  output logic               memAccessD,
  output logic               addOffsetD,
  output pipePkg::resSelT    resultSelD,
  output logic [`REG_AW-1:0] ra1D,
  output logic [`REG_AW-1:0] ra2D,
  output logic [`REG_AW-1:0] waD
);

  // Register fields
  logic [`REG_AW-1:0] rnD;
  logic [`REG_AW-1:0] rdD;
  logic [`REG_AW-1:0] rmD;

  assign rnD = instrD[19:16];
  assign rdD = instrD[15:12];
  assign rmD = instrD[3:0];

  always_comb begin
    // Defaults describe a no-operation
    aluOpD     = instrPkg::OP_AND;
    shiftTypeD = instrPkg::shiftT'(instrD[6:5]);
    srcBD      = instrPkg::SRC_SHREG;
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memAccessD = 1'b0;
    addOffsetD = 1'b1;
    resultSelD = pipePkg::RES_ALU;
    ra1D       = rnD;
    ra2D       = rmD;
    waD        = rdD;

    case (instrD[27:26])
      // ====================
      // Data processing
      // ====================
      2'b00: begin
        // Bit 4 with I clear is a register-shifted register or multiply
        if (instrD[25] || !instrD[4]) begin
          srcBD = instrD[25] ? instrPkg::SRC_ROTIMM : instrPkg::SRC_SHREG;
          case (instrD[24:21])
            instrPkg::OP_AND, instrPkg::OP_EOR, instrPkg::OP_SUB, instrPkg::OP_RSB,
            instrPkg::OP_ADD, instrPkg::OP_ORR, instrPkg::OP_MOV, instrPkg::OP_MVN: begin
              aluOpD    = instrPkg::dpOpT'(instrD[24:21]);
              regWriteD = 1'b1;
            end
            // Compares and the rest write nothing here
            default: regWriteD = 1'b0;
          endcase
        end
      end

      // ====================
      // Word load/store
      // ====================
      2'b01: begin
        // Immediate offset, pre-indexed, word, no writeback
        if (!instrD[25] && instrD[24] && !instrD[22] && !instrD[21]) begin
          srcBD      = instrPkg::SRC_OFFSET;
          memAccessD = 1'b1;
          addOffsetD = instrD[23];
          if (instrD[20]) begin
            // LDR
            regWriteD  = 1'b1;
            resultSelD = pipePkg::RES_MEM;
          end else begin
            // STR reads Rd as store data
            memWriteD = 1'b1;
            ra2D      = rdD;
          end
        end
      end

      default: regWriteD = 1'b0;
    endcase
  end

endmodule

/* hazardUnit.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module hazardUnit (
  input  logic [`REG_AW-1:0] ra1E,
  input  logic [`REG_AW-1:0] ra2E,
  input  logic [`REG_AW-1:0] waM,
  input  logic [`REG_AW-1:0] waW,
  input  logic [`REG_AW-1:0] ra1D,
  input  logic [`REG_AW-1:0] ra2D,
  input  logic [`REG_AW-1:0] waE,
  input  logic               regWriteM,
  input  logic               regWriteW,
  input  logic               loadE,
  output pipePkg::fwdT       forwardAE,
  output pipePkg::fwdT       forwardBE,
  output logic               stallF,
  output logic               stallD,
  output logic               flushE
);

  logic loadUse;

  // Forward source for one execute operand
  // Memory stage is the newest value, so it wins over writeback
  function automatic pipePkg::fwdT fwdSel(input logic [`REG_AW-1:0] ra,
                                          input logic [`REG_AW-1:0] wM,
                                          input logic               weM,
                                          input logic [`REG_AW-1:0] wW,
                                          input logic               weW);
    if (weM && (wM == ra)) begin
      return pipePkg::FWD_MEM;
    end
    if (weW && (wW == ra)) begin
      return pipePkg::FWD_WB;
    end
    return pipePkg::FWD_RF;
  endfunction

  assign forwardAE = fwdSel(ra1E, waM, regWriteM, waW, regWriteW);
  assign forwardBE = fwdSel(ra2E, waM, regWriteM, waW, regWriteW);

  // Load data exists only from writeback on
  // A reader right behind the load waits one cycle
  assign loadUse = loadE && ((waE == ra1D) || (waE == ra2D));

  // Hold fetch and decode, send a bubble into execute
  assign stallF = loadUse;
  assign stallD = loadUse;
  assign flushE = loadUse;

endmodule

/* instrPkg.sv */
package instrPkg;

  // Data-processing opcodes, coded as in instruction bits 24:21
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_RSB = 4'b0011,
    OP_ADD = 4'b0100,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101,
    OP_MVN = 4'b1111
  } dpOpT;

  // Shift type, coded as in instruction bits 6:5
  typedef enum logic [1:0] {
    SH_LSL = 2'b00,
    SH_LSR = 2'b01,
    SH_ASR = 2'b10,
    SH_ROR = 2'b11
  } shiftT;

  // Source of the second ALU operand
  typedef enum logic [1:0] {
    SRC_ROTIMM = 2'b00,
    SRC_SHREG  = 2'b01,
    SRC_OFFSET = 2'b10
  } srcBT;

endpackage

/* pipePkg.sv */
package pipePkg;

  // Execute operand source
  // Register file value, writeback result or memory-stage ALU result
  typedef enum logic [1:0] {
    FWD_RF  = 2'b00,
    FWD_WB  = 2'b01,
    FWD_MEM = 2'b10
  } fwdT;

  // Writeback result source
  typedef enum logic {
    RES_ALU = 1'b0,
    RES_MEM = 1'b1
  } resSelT;

endpackage

/* regFile.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module regFile (
  input  logic               clk,
  input  logic               arstN,
  input  logic               we,
  input  logic [`REG_AW-1:0] ra1,
  input  logic [`REG_AW-1:0] ra2,
  input  logic [`REG_AW-1:0] wa,
  input  logic [`DATA_W-1:0] wd,
  output logic [`DATA_W-1:0] rd1,
  output logic [`DATA_W-1:0] rd2
);

  // Architectural registers
  logic [`DATA_W-1:0] regs [`NUM_REGS];

  // Write on the falling edge
  // A decode read in the writeback cycle then sees the new value
  always_ff @(negedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Combinational read ports
  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

/* shifter.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module shifter (
  input  instrPkg::srcBT     srcB,
  input  logic [31:0]        instr,
  input  logic [`DATA_W-1:0] rm,
  input  instrPkg::shiftT    shiftType,
  output logic [`DATA_W-1:0] operand
);

  logic [`DATA_W-1:0] immExt;
  logic [`DATA_W-1:0] rotImm;
  logic [`DATA_W-1:0] regShift;
  logic [`DATA_W-1:0] offsetExt;
  // Twice the rotate field, 0 to 30
  logic [5:0]         rotAmt;
  logic [4:0]         shAmt;

  // Rotated immediate
  // A zero rotate makes the left term a 32-bit shift, which is zero
  assign immExt = {{(`DATA_W-8){1'b0}}, instr[7:0]};
  assign rotAmt = {1'b0, instr[11:8], 1'b0};
  assign rotImm = (immExt >> rotAmt) | (immExt << (6'd32 - rotAmt));

  // Register shifted by the immediate amount
  assign shAmt = instr[11:7];

  always_comb begin
    case (shiftType)
      instrPkg::SH_LSL: regShift = rm << shAmt;
      // Zero amount encodes a full 32-bit shift
      instrPkg::SH_LSR: regShift = (shAmt == 5'd0) ? '0 : (rm >> shAmt);
      instrPkg::SH_ASR: regShift = (shAmt == 5'd0) ? {`DATA_W{rm[`DATA_W-1]}} :
                                   `DATA_W'($signed(rm) >>> shAmt);
      // Zero amount leaves the value unchanged here
      default: regShift = (shAmt == 5'd0) ? rm :
                          ((rm >> shAmt) | (rm << (6'd32 - {1'b0, shAmt})));
    endcase
  end

  // Load/store offset, always zero-extended
  assign offsetExt = {{(`DATA_W-12){1'b0}}, instr[11:0]};

  // Second operand select
  always_comb begin
    case (srcB)
      instrPkg::SRC_ROTIMM: operand = rotImm;
      instrPkg::SRC_OFFSET: operand = offsetExt;
      default:              operand = regShift;
    endcase
  end

endmodule

/* sources.f */
+incdir+.
instrPkg.sv
pipePkg.sv
regFile.sv
shifter.sv
alu.sv
hazardUnit.sv
decoder.sv
datapath.sv
armCore.sv
armCore_asserts.sv
tb_armCore.sv

/* tb_armCore.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module tb_armCore;

  localparam int resetCycles = 16;
  localparam int romWords    = 64;
  localparam int ramWords    = 64;
  localparam int progLen     = 32;
  localparam int numStores   = 14;
  localparam int tailCycles  = 40;
  // Eight cycles per instruction is far above the real CPI with stalls
  localparam int cycleLimit  = resetCycles + progLen * 8 + 28;
  // CMP r0, #0 writes nothing in this core
  localparam logic [31:0] nopInstr = 32'hE350_0000;

  logic               clk;
  logic               arstN;
  logic [`DATA_W-1:0] instrF;
  logic [`DATA_W-1:0] readDataM;
  logic [`DATA_W-1:0] pcF;
  logic [`DATA_W-1:0] aluOutM;
  logic [`DATA_W-1:0] writeDataM;
  logic               dataWe;

  logic [31:0]        rom [romWords];
  logic [`DATA_W-1:0] ram [ramWords];
  logic [`DATA_W-1:0] expAddr [numStores];
  logic [`DATA_W-1:0] expData [numStores];
  int                 errCount;
  int                 checkCount;
  int                 cycleCount;

  armCore dut (.clk(clk), .arstN(arstN), .instrF(instrF), .readDataM(readDataM),
               .pcF(pcF), .aluOutM(aluOutM), .writeDataM(writeDataM), .dataWe(dataWe));

  bind datapath armCore_asserts chk (.clk(clk), .arstN(arstN), .dataWe(dataWe),
                                     .pcF(pcF), .stallF(stallF), .stallD(stallD));

  // ====================
  // Clock and memories
  // ====================
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Instruction ROM, word indexed, combinational read
  assign instrF = (pcF[31:8] == '0) ? rom[pcF[7:2]] : nopInstr;

  // Data RAM, combinational read and write on the rising edge
  assign readDataM = (aluOutM[31:8] == '0) ? ram[aluOutM[7:2]] : ~aluOutM;

  always @(posedge clk) begin
    if (dataWe && (aluOutM[31:8] == '0)) begin
      ram[aluOutM[7:2]] <= writeDataM;
    end
  end

  // Test program, with results worked out from the ARM rules
  task automatic loadProgram();
    // Filler is CMP r0, #index, which writes nothing
    for (int i = 0; i < romWords; i++) begin
      rom[i] = nopInstr | i;
    end
    // Rotated immediates
    rom[0]  = 32'hE3A0_10AB;  // MOV r1, #0xAB
    rom[1]  = 32'hE3A0_24FF;  // MOV r2, #0xFF ror 8 = 0xFF000000
    rom[2]  = 32'hE3E0_300F;  // MVN r3, #0x0F = 0xFFFFFFF0
    rom[3]  = 32'hE3A0_A040;  // MOV r10, #0x40 as store base
    rom[4]  = 32'hE58A_1000;  // STR r1, [r10, #0]
    rom[5]  = 32'hE58A_2004;
    rom[6]  = 32'hE58A_3008;
    // Dependent chain, forwarding from M and W
    rom[7]  = 32'hE081_4002;  // ADD r4, r1, r2 = 0xFF0000AB
    rom[8]  = 32'hE044_5001;  // SUB r5, r4, r1 = 0xFF000000
    rom[9]  = 32'hE065_6004;  // RSB r6, r5, r4 = 0xAB
    rom[10] = 32'hE006_7003;  // AND r7, r6, r3 = 0xA0
    rom[11] = 32'hE187_8002;  // ORR r8, r7, r2 = 0xFF0000A0
    rom[12] = 32'hE028_9004;  // EOR r9, r8, r4 = 0x0B
    rom[13] = 32'hE58A_400C;
    rom[14] = 32'hE58A_6010;
    rom[15] = 32'hE58A_9014;
    // Shifted register operands
    rom[16] = 32'hE1A0_B243;  // MOV r11, r3, ASR #4 = 0xFFFFFFFF
    rom[17] = 32'hE1A0_C401;  // MOV r12, r1, LSL #8 = 0xAB00
    rom[18] = 32'hE1A0_D022;  // MOV r13, r2, LSR #32 = 0
    rom[19] = 32'hE1A0_E261;  // MOV r14, r1, ROR #4 = 0xB000000A
    rom[20] = 32'hE1A0_5C22;  // MOV r5, r2, LSR #24 = 0xFF
    rom[21] = 32'hE58A_B018;
    rom[22] = 32'hE58A_C01C;
    rom[23] = 32'hE58A_D020;
    rom[24] = 32'hE58A_E024;
    rom[25] = 32'hE58A_5028;
    // U bit clear, base minus offset
    rom[26] = 32'hE50A_7008;  // STR r7, [r10, #-8]
    // Load-use on Rn, then on the store data
    rom[27] = 32'hE59A_9040;  // LDR r9, [r10, #64]
    rom[28] = 32'hE089_9001;  // ADD r9, r9, r1
    rom[29] = 32'hE58A_902C;
    rom[30] = 32'hE59A_8044;  // LDR r8, [r10, #68]
    rom[31] = 32'hE50A_8004;  // STR r8, [r10, #-4]
  endtask

  // One row of the expected-store table
  task automatic setExpected(input int idx, input logic [`DATA_W-1:0] addr,
                             input logic [`DATA_W-1:0] data);
    expAddr[idx] = addr;
    expData[idx] = data;
  endtask

  // Expected stores in program order
  task automatic loadTable();
    setExpected(0,  32'h40, 32'h0000_00AB);
    setExpected(1,  32'h44, 32'hFF00_0000);
    setExpected(2,  32'h48, 32'hFFFF_FFF0);
    setExpected(3,  32'h4C, 32'hFF00_00AB);
    setExpected(4,  32'h50, 32'h0000_00AB);
    setExpected(5,  32'h54, 32'h0000_000B);
    setExpected(6,  32'h58, 32'hFFFF_FFFF);
    setExpected(7,  32'h5C, 32'h0000_AB00);
    setExpected(8,  32'h60, 32'h0000_0000);
    setExpected(9,  32'h64, 32'hB000_000A);
    setExpected(10, 32'h68, 32'h0000_00FF);
    setExpected(11, 32'h38, 32'h0000_00A0);
    // 0x12345678 + 0xAB
    setExpected(12, 32'h6C, 32'h1234_5723);
    setExpected(13, 32'h3C, 32'h0BAD_F00D);
  endtask

  // Sampled at the falling edge, away from register updates
  task automatic waitStore();
    @(negedge clk);
    while (!dataWe) begin
      @(negedge clk);
    end
  endtask

  task automatic compareStore(input int idx);
    checkCount++;
    if (aluOutM !== expAddr[idx]) begin
      errCount++;
      $display("ERR %0t: store %0d address expected %h, got %h",
               $time, idx, expAddr[idx], aluOutM);
    end
    if (writeDataM !== expData[idx]) begin
      errCount++;
      $display("ERR %0t: store %0d data expected %h, got %h",
               $time, idx, expData[idx], writeDataM);
    end
  endtask

  // ====================
  // Monitors
  // ====================

  // No store strobe while the core is held in reset
  always @(negedge clk) begin
    if (!arstN && dataWe) begin
      errCount++;
      $display("ERR %0t: dataWe high during reset", $time);
    end
    // PC sits at the reset address until released
    if (!arstN && (pcF !== `RESET_PC)) begin
      errCount++;
      $display("ERR %0t: pcF expected %h during reset, got %h", $time, `RESET_PC, pcF);
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the program did not finish within %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  // ====================
  // Main sequence
  // ====================
  initial begin
    errCount   = 0;
    checkCount = 0;
    cycleCount = 0;
    arstN      = 1'b0;
    loadProgram();
    for (int i = 0; i < ramWords; i++) begin
      ram[i] = 32'hDA7A_0000 | i;
    end
    // Preloaded words for the two loads
    ram[32] = 32'h1234_5678;
    ram[33] = 32'h0BAD_F00D;
    loadTable();

    repeat (resetCycles) @(posedge clk);
    #2 arstN = 1'b1;

    for (int k = 0; k < numStores; k++) begin
      waitStore();
      compareStore(k);
    end

    // Nothing more may be written once the table is done
    repeat (tailCycles) begin
      @(negedge clk);
      if (dataWe) begin
        errCount++;
        $display("ERR %0t: extra store to %h with data %h", $time, aluOutM, writeDataM);
      end
    end

    // Add failures of the bound assertions
    errCount += dut.dp.chk.failCount;
    $display("Stores checked: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
